// ==== verilog.f ====
+incdir+testbench
common/la_decode_pkg.sv
decoder/alu_decoder.sv
decoder/mem_decoder.sv
decoder/branch_decoder.sv
decoder/dispatch_merge.sv
hdl/id_stage.sv
testbench/tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_id_stage -f verilog.f \
    -o sim_id_stage > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_id_stage > sim.log 2>&1

grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "No verdict in sim.log"; exit 1; }
echo "Simulation passed"

// ==== testbench/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Reference decode of one LA32R word, built from the instruction tables.
function automatic void model_decode(
    input  logic [31:0] inst,
    output decode_t     d,
    output logic        exc,
    output exc_cause_e  cause
);
    aluop_e op;

    d     = DECODE_NOP;
    exc   = 1'b0;
    cause = EXC_INE;
    op    = ALU_NOP;

    case (inst[31:22])
        OP1_SLTI:  op = ALU_SLTI;
        OP1_SLTUI: op = ALU_SLTUI;
        OP1_ADDIW: op = ALU_ADDIW;
        OP1_ANDI:  op = ALU_ANDI;
        OP1_ORI:   op = ALU_ORI;
        OP1_XORI:  op = ALU_XORI;
        OP1_LDB:   op = ALU_LDB;
        OP1_LDH:   op = ALU_LDH;
        OP1_LDW:   op = ALU_LDW;
        OP1_LDBU:  op = ALU_LDBU;
        OP1_LDHU:  op = ALU_LDHU;
        OP1_STB:   op = ALU_STB;
        OP1_STH:   op = ALU_STH;
        OP1_STW:   op = ALU_STW;
        default: ;
    endcase
    case (inst[31:15])
        OP2_ADDW:   op = ALU_ADDW;
        OP2_SUBW:   op = ALU_SUBW;
        OP2_SLT:    op = ALU_SLT;
        OP2_SLTU:   op = ALU_SLTU;
        OP2_NOR:    op = ALU_NOR;
        OP2_AND:    op = ALU_AND;
        OP2_OR:     op = ALU_OR;
        OP2_XOR:    op = ALU_XOR;
        OP2_SLLW:   op = ALU_SLLW;
        OP2_SRLW:   op = ALU_SRLW;
        OP2_SRAW:   op = ALU_SRAW;
        OP2_MULW:   op = ALU_MULW;
        OP2_MULHW:  op = ALU_MULHW;
        OP2_MULHWU: op = ALU_MULHWU;
        OP2_DIVW:   op = ALU_DIVW;
        OP2_MODW:   op = ALU_MODW;
        OP2_DIVWU:  op = ALU_DIVWU;
        OP2_MODWU:  op = ALU_MODWU;
        OP2_SLLIW:  op = ALU_SLLIW;
        OP2_SRLIW:  op = ALU_SRLIW;
        OP2_SRAIW:  op = ALU_SRAIW;
        default: ;
    endcase
    case (inst[31:25])
        OP3_LU12I:     op = ALU_LU12I;
        OP3_PCADDU12I: op = ALU_PCADDU12I;
        default: ;
    endcase
    // BLTU and BGEU share the signed compare ops.
    case (inst[31:26])
        OP5_BEQ:  op = ALU_BEQ;
        OP5_BNE:  op = ALU_BNE;
        OP5_BLT:  op = ALU_BLT;
        OP5_BGE:  op = ALU_BGE;
        OP5_BLTU: op = ALU_BLT;
        OP5_BGEU: op = ALU_BGE;
        OP5_B:    op = ALU_B;
        OP5_BL:   op = ALU_BL;
        OP5_JIRL: op = ALU_JIRL;
        default: ;
    endcase

    if (inst[31:15] == OP2_BREAK) begin
        exc   = 1'b1;
        cause = EXC_BRK;
        return;
    end
    if (inst[31:15] == OP2_SYSCALL) begin
        exc   = 1'b1;
        cause = EXC_SYS;
        return;
    end
    if (op == ALU_NOP) begin
        exc = (inst != 32'd0);
        return;
    end

    d.aluop = op;
    case (op)
        ALU_NOR, ALU_AND, ALU_OR, ALU_XOR, ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LU12I:
            d.alusel = ALU_SEL_LOGIC;
        ALU_SLLW, ALU_SRLW, ALU_SRAW, ALU_SLLIW, ALU_SRLIW, ALU_SRAIW, ALU_SLTI, ALU_SLTUI:
            d.alusel = ALU_SEL_SHIFT;
        ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU, ALU_STB, ALU_STH, ALU_STW:
            d.alusel = ALU_SEL_LOAD_STORE;
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_B, ALU_BL, ALU_JIRL:
            d.alusel = ALU_SEL_JUMP_BRANCH;
        default:
            d.alusel = ALU_SEL_ARITHMETIC;
    endcase

    case (op)
        ALU_SLTI, ALU_SLTUI, ALU_ADDIW, ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU:
            d.imm = {{20{inst[21]}}, inst[21:10]};
        ALU_ANDI, ALU_ORI, ALU_XORI:
            d.imm = {20'b0, inst[21:10]};
        ALU_SLLIW, ALU_SRLIW, ALU_SRAIW:
            d.imm = {27'b0, inst[14:10]};
        ALU_LU12I, ALU_PCADDU12I:
            d.imm = {inst[24:5], 12'b0};
        default:
            d.imm = 32'd0;
    endcase

    d.reg1_read_addr = inst[9:5];
    d.reg2_read_addr = inst[14:10];
    case (d.alusel)
        ALU_SEL_LOAD_STORE: begin
            d.reg1_read_en = 1'b1;
            if (op inside {ALU_STB, ALU_STH, ALU_STW}) begin
                d.reg2_read_en   = 1'b1;
                d.reg2_read_addr = inst[4:0];
            end else begin
                d.reg_write_en   = 1'b1;
                d.reg_write_addr = inst[4:0];
            end
        end
        ALU_SEL_JUMP_BRANCH: begin
            if (op == ALU_BL) begin
                d.reg_write_en   = 1'b1;
                d.reg_write_addr = 5'd1;
            end else if (op == ALU_JIRL) begin
                d.reg1_read_en   = 1'b1;
                d.reg_write_en   = 1'b1;
                d.reg_write_addr = inst[4:0];
            end else if (op != ALU_B) begin
                d.reg1_read_en   = 1'b1;
                d.reg2_read_en   = 1'b1;
                d.reg2_read_addr = inst[4:0];
            end
        end
        default: begin
            d.reg1_read_en   = 1'b1;
            d.reg2_read_en   = op inside {ALU_NOR, ALU_AND, ALU_OR, ALU_XOR, ALU_SLLW,
                ALU_SRLW, ALU_SRAW, ALU_ADDW, ALU_SUBW, ALU_SLT, ALU_SLTU, ALU_MULW,
                ALU_MULHW, ALU_MULHWU, ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU};
            d.reg_write_en   = 1'b1;
            d.reg_write_addr = inst[4:0];
            // LU12I adds to r0.
            if (op == ALU_LU12I) begin
                d.reg1_read_addr = 5'd0;
            end
        end
    endcase
endfunction

`endif

// ==== testbench/tb_id_stage.sv ====
`default_nettype none

module tb_id_stage
    import la_decode_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CYCLES   = 4000;
    localparam int SETTLE_LIMIT = 20;
    localparam int DRAIN_LIMIT  = 20;

    localparam logic [9:0] OP1_TAB [14] = '{
        OP1_SLTI, OP1_SLTUI, OP1_ADDIW, OP1_ANDI, OP1_ORI, OP1_XORI, OP1_LDB,
        OP1_LDH, OP1_LDW, OP1_LDBU, OP1_LDHU, OP1_STB, OP1_STH, OP1_STW
    };
    localparam logic [16:0] OP2_TAB [23] = '{
        OP2_ADDW, OP2_SUBW, OP2_SLT, OP2_SLTU, OP2_NOR, OP2_AND, OP2_OR, OP2_XOR,
        OP2_SLLW, OP2_SRLW, OP2_SRAW, OP2_MULW, OP2_MULHW, OP2_MULHWU, OP2_DIVW,
        OP2_MODW, OP2_DIVWU, OP2_MODWU, OP2_BREAK, OP2_SYSCALL, OP2_SLLIW,
        OP2_SRLIW, OP2_SRAIW
    };
    localparam logic [6:0] OP3_TAB [2] = '{OP3_LU12I, OP3_PCADDU12I};
    localparam logic [5:0] OP5_TAB [9] = '{
        OP5_JIRL, OP5_B, OP5_BL, OP5_BEQ, OP5_BNE, OP5_BLT, OP5_BGE, OP5_BLTU, OP5_BGEU
    };

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        decode_t         dec;
        logic            exc;
        exc_cause_e      cause;
    } expect_t;

    logic                  clk;
    logic                  reset_i;
    logic                  inst_valid_i;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       inst_i;
    logic                  dispatch_valid_o;
    logic [XLEN-1:0]       pc_o;
    aluop_e                aluop_o;
    alusel_e               alusel_o;
    logic                  reg1_read_en_o;
    logic [REG_ADDR_W-1:0] reg1_read_addr_o;
    logic                  reg2_read_en_o;
    logic [REG_ADDR_W-1:0] reg2_read_addr_o;
    logic                  reg_write_en_o;
    logic [REG_ADDR_W-1:0] reg_write_addr_o;
    logic [XLEN-1:0]       imm_o;
    logic                  exception_o;
    exc_cause_e            exception_cause_o;

    expect_t pending_q [$];
    expect_t held;
    logic    pc_known;

    `include "decode_model.svh"

    id_stage i_id_stage (
        .clk               (clk),
        .reset_i           (reset_i),
        .inst_valid_i      (inst_valid_i),
        .pc_i              (pc_i),
        .inst_i            (inst_i),
        .dispatch_valid_o  (dispatch_valid_o),
        .pc_o              (pc_o),
        .aluop_o           (aluop_o),
        .alusel_o          (alusel_o),
        .reg1_read_en_o    (reg1_read_en_o),
        .reg1_read_addr_o  (reg1_read_addr_o),
        .reg2_read_en_o    (reg2_read_en_o),
        .reg2_read_addr_o  (reg2_read_addr_o),
        .reg_write_en_o    (reg_write_en_o),
        .reg_write_addr_o  (reg_write_addr_o),
        .imm_o             (imm_o),
        .exception_o       (exception_o),
        .exception_cause_o (exception_cause_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first mismatch.");
    endtask

    function automatic string decode_str(input decode_t d);
        return $sformatf("op=%h sel=%0d r1=%b/%0d r2=%b/%0d w=%b/%0d imm=%h",
            d.aluop, d.alusel, d.reg1_read_en, d.reg1_read_addr, d.reg2_read_en,
            d.reg2_read_addr, d.reg_write_en, d.reg_write_addr, d.imm);
    endfunction

    function automatic decode_t dut_decode();
        decode_t d;
        d.aluop          = aluop_o;
        d.alusel         = alusel_o;
        d.reg1_read_en   = reg1_read_en_o;
        d.reg1_read_addr = reg1_read_addr_o;
        d.reg2_read_en   = reg2_read_en_o;
        d.reg2_read_addr = reg2_read_addr_o;
        d.reg_write_en   = reg_write_en_o;
        d.reg_write_addr = reg_write_addr_o;
        d.imm            = imm_o;
        return d;
    endfunction

    task automatic check_decode(input decode_t exp, input decode_t act);
        if (act !== exp) begin
            fail_now($sformatf("ERROR %0t decode outputs expected %s actual %s",
                $time, decode_str(exp), decode_str(act)));
        end
    endtask

    task automatic check_exception(input logic exp_exc, input exc_cause_e exp_cause,
                                   input logic act_exc, input exc_cause_e act_cause);
        if (act_exc !== exp_exc) begin
            fail_now($sformatf("ERROR %0t exception_o expected %b actual %b",
                $time, exp_exc, act_exc));
        end
        if (exp_exc && act_cause !== exp_cause) begin
            fail_now($sformatf("ERROR %0t exception_cause_o expected %h actual %h",
                $time, exp_cause, act_cause));
        end
    endtask

    task automatic check_pc(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (act !== exp) begin
            fail_now($sformatf("ERROR %0t pc_o expected %h actual %h", $time, exp, act));
        end
    endtask

    task automatic check_strobe(input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("ERROR %0t dispatch_valid_o expected %b actual %b",
                $time, exp, act));
        end
    endtask

    // Outputs hold the last valid decode on idle cycles.
    task automatic check_pending();
        expect_t e;
        e = pending_q.pop_front();
        check_strobe(e.valid, dispatch_valid_o);
        if (e.valid) begin
            held     = e;
            pc_known = 1'b1;
        end
        check_decode(held.dec, dut_decode());
        check_exception(held.exc, held.cause, exception_o, exception_cause_o);
        if (pc_known) begin
            check_pc(held.pc, pc_o);
        end
    endtask

    function automatic logic [XLEN-1:0] kept_word(input logic [XLEN-1:0] fields);
        logic [XLEN-1:0] w;
        w = fields;
        case ($urandom_range(3, 0))
            0: w[31:22] = OP1_TAB[4'($urandom_range(13, 0))];
            1: w[31:15] = OP2_TAB[5'($urandom_range(22, 0))];
            2: w[31:25] = OP3_TAB[1'($urandom_range(1, 0))];
            default: w[31:26] = OP5_TAB[4'($urandom_range(8, 0))];
        endcase
        return w;
    endfunction

    task automatic drive_random();
        expect_t         e;
        logic [XLEN-1:0] word;
        decode_t         d;
        logic            exc;
        exc_cause_e      cause;
        int unsigned     pick;
        pick = $urandom_range(9, 0);
        if (pick < 6) begin
            word = kept_word($urandom());
        end else if (pick < 9) begin
            word = $urandom();
        end else begin
            word = '0;
        end
        model_decode(word, d, exc, cause);
        e.valid = ($urandom_range(4, 0) != 0);
        e.pc    = $urandom() & 32'hffff_fffc;
        e.dec   = d;
        e.exc   = exc;
        e.cause = cause;
        inst_valid_i = e.valid;
        pc_i         = e.pc;
        inst_i       = word;
        pending_q.push_back(e);
    endtask

    initial begin
        int unsigned cycles;
        void'($urandom(32'ha3b6_393b));
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        held.valid   = 1'b0;
        held.pc      = '0;
        held.dec     = DECODE_NOP;
        held.exc     = 1'b0;
        held.cause   = EXC_INE;
        pc_known     = 1'b0;

        repeat (5) @(negedge clk);
        reset_i = 1'b0;

        // Wait for the status outputs to leave the unknown state.
        cycles = 0;
        while ($isunknown({dispatch_valid_o, exception_o})) begin
            @(negedge clk);
            cycles++;
            if (cycles > SETTLE_LIMIT) begin
                fail_now("The DUT outputs did not reach the reset state in time.");
            end
        end
        check_strobe(1'b0, dispatch_valid_o);
        check_decode(DECODE_NOP, dut_decode());
        check_exception(1'b0, EXC_INE, exception_o, exception_cause_o);

        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(negedge clk);
            if (pending_q.size() != 0) begin
                check_pending();
            end
            drive_random();
        end

        cycles = 0;
        while (pending_q.size() != 0) begin
            @(negedge clk);
            check_pending();
            inst_valid_i = 1'b0;
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                fail_now("Queued decode results were not drained in time.");
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/id_stage.sv ====
`default_nettype none

module id_stage
    import la_decode_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  inst_valid_i,
    input  wire logic [XLEN-1:0]       pc_i,
    input  wire logic [XLEN-1:0]       inst_i,
    output logic                       dispatch_valid_o,
    output logic [XLEN-1:0]            pc_o,
    output aluop_e                     aluop_o,
    output alusel_e                    alusel_o,
    output logic                       reg1_read_en_o,
    output logic [REG_ADDR_W-1:0]      reg1_read_addr_o,
    output logic                       reg2_read_en_o,
    output logic [REG_ADDR_W-1:0]      reg2_read_addr_o,
    output logic                       reg_write_en_o,
    output logic [REG_ADDR_W-1:0]      reg_write_addr_o,
    output logic [XLEN-1:0]            imm_o,
    output logic                       exception_o,
    output exc_cause_e                 exception_cause_o
);

    logic    alu_hit;
    logic    mem_hit;
    logic    branch_hit;
    decode_t alu_dec;
    decode_t mem_dec;
    decode_t branch_dec;
    decode_t dec;

    alu_decoder i_alu_decoder (
        .inst_i (inst_i),
        .hit_o  (alu_hit),
        .dec_o  (alu_dec)
    );

    mem_decoder i_mem_decoder (
        .inst_i (inst_i),
        .hit_o  (mem_hit),
        .dec_o  (mem_dec)
    );

    branch_decoder i_branch_decoder (
        .inst_i (inst_i),
        .hit_o  (branch_hit),
        .dec_o  (branch_dec)
    );

    dispatch_merge i_dispatch_merge (
        .clk               (clk),
        .reset_i           (reset_i),
        .inst_valid_i      (inst_valid_i),
        .pc_i              (pc_i),
        .inst_i            (inst_i),
        .alu_hit_i         (alu_hit),
        .mem_hit_i         (mem_hit),
        .branch_hit_i      (branch_hit),
        .alu_dec_i         (alu_dec),
        .mem_dec_i         (mem_dec),
        .branch_dec_i      (branch_dec),
        .dispatch_valid_o  (dispatch_valid_o),
        .pc_o              (pc_o),
        .dec_o             (dec),
        .exception_o       (exception_o),
        .exception_cause_o (exception_cause_o)
    );

    assign aluop_o          = dec.aluop;
    assign alusel_o         = dec.alusel;
    assign reg1_read_en_o   = dec.reg1_read_en;
    assign reg1_read_addr_o = dec.reg1_read_addr;
    assign reg2_read_en_o   = dec.reg2_read_en;
    assign reg2_read_addr_o = dec.reg2_read_addr;
    assign reg_write_en_o   = dec.reg_write_en;
    assign reg_write_addr_o = dec.reg_write_addr;
    assign imm_o            = dec.imm;

endmodule

`default_nettype wire

// ==== decoder/dispatch_merge.sv ====
`default_nettype none

module dispatch_merge
    import la_decode_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire logic            inst_valid_i,
    input  wire logic [XLEN-1:0] pc_i,
    input  wire logic [XLEN-1:0] inst_i,
    input  wire logic            alu_hit_i,
    input  wire logic            mem_hit_i,
    input  wire logic            branch_hit_i,
    input  wire decode_t         alu_dec_i,
    input  wire decode_t         mem_dec_i,
    input  wire decode_t         branch_dec_i,
    output logic                 dispatch_valid_o,
    output logic [XLEN-1:0]      pc_o,
    output decode_t              dec_o,
    output logic                 exception_o,
    output exc_cause_e           exception_cause_o
);

    logic       is_break;
    logic       is_syscall;
    decode_t    dec_next;
    logic       exc_next;
    exc_cause_e cause_next;

    assign is_break   = (inst_i[31:15] == OP2_BREAK);
    assign is_syscall = (inst_i[31:15] == OP2_SYSCALL);

    always_comb begin
        dec_next   = DECODE_NOP;
        exc_next   = 1'b0;
        cause_next = EXC_INE;
        if (is_break) begin
            exc_next   = 1'b1;
            cause_next = EXC_BRK;
        end else if (is_syscall) begin
            exc_next   = 1'b1;
            cause_next = EXC_SYS;
        end else if (alu_hit_i) begin
            dec_next = alu_dec_i;
        end else if (mem_hit_i) begin
            dec_next = mem_dec_i;
        end else if (branch_hit_i) begin
            dec_next = branch_dec_i;
        end else if (inst_i != '0) begin
            // Nothing matched, and the zero word is a plain NOP.
            exc_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dispatch_valid_o  <= 1'b0;
            exception_o       <= 1'b0;
            exception_cause_o <= EXC_INE;
            dec_o             <= DECODE_NOP;
        end else begin
            dispatch_valid_o <= inst_valid_i;
            if (inst_valid_i) begin
                exception_o       <= exc_next;
                exception_cause_o <= cause_next;
                dec_o             <= dec_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            pc_o <= pc_i;
        end
    end

    // The three decoders cover disjoint opcode groups.
    hit_onehot_a: assert property (@(posedge clk) disable iff (reset_i)
        inst_valid_i |-> $onehot0({alu_hit_i, mem_hit_i, branch_hit_i}));

    // A trapping instruction never reaches the register file.
    exc_no_write_a: assert property (@(posedge clk) disable iff (reset_i)
        (dispatch_valid_o && exception_o) |-> !dec_o.reg_write_en);

endmodule

`default_nettype wire

// ==== decoder/branch_decoder.sv ====
`default_nettype none

module branch_decoder
    import la_decode_pkg::*;
(
    input  wire logic [XLEN-1:0] inst_i,
    output logic                 hit_o,
    output decode_t              dec_o
);

    aluop_e aluop;

    // Unsigned compares share the signed ALU ops.
    always_comb begin
        aluop = ALU_NOP;
        case (inst_i[31:26])
            OP5_BEQ:            aluop = ALU_BEQ;
            OP5_BNE:            aluop = ALU_BNE;
            OP5_BLT, OP5_BLTU:  aluop = ALU_BLT;
            OP5_BGE, OP5_BGEU:  aluop = ALU_BGE;
            OP5_B:              aluop = ALU_B;
            OP5_BL:             aluop = ALU_BL;
            OP5_JIRL:           aluop = ALU_JIRL;
            default: ;
        endcase
    end

    assign hit_o = (aluop != ALU_NOP);

    // Offsets stay in the instruction word for the execute stage.
    always_comb begin
        dec_o = DECODE_NOP;
        if (hit_o) begin
            dec_o.aluop          = aluop;
            dec_o.alusel         = sel_of(aluop);
            dec_o.reg1_read_addr = rj_of(inst_i);
            dec_o.reg2_read_addr = rk_of(inst_i);
            case (aluop)
                ALU_B: begin
                end
                ALU_BL: begin
                    dec_o.reg_write_en   = 1'b1;
                    dec_o.reg_write_addr = LINK_REG;
                end
                ALU_JIRL: begin
                    dec_o.reg1_read_en   = 1'b1;
                    dec_o.reg_write_en   = 1'b1;
                    dec_o.reg_write_addr = rd_of(inst_i);
                end
                default: begin
                    dec_o.reg1_read_en   = 1'b1;
                    dec_o.reg2_read_en   = 1'b1;
                    dec_o.reg2_read_addr = rd_of(inst_i);
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== decoder/mem_decoder.sv ====
`default_nettype none

module mem_decoder
    import la_decode_pkg::*;
(
    input  wire logic [XLEN-1:0] inst_i,
    output logic                 hit_o,
    output decode_t              dec_o
);

    aluop_e aluop;
    logic   is_store;

    always_comb begin
        aluop = ALU_NOP;
        case (inst_i[31:22])
            OP1_LDB:  aluop = ALU_LDB;
            OP1_LDH:  aluop = ALU_LDH;
            OP1_LDW:  aluop = ALU_LDW;
            OP1_LDBU: aluop = ALU_LDBU;
            OP1_LDHU: aluop = ALU_LDHU;
            OP1_STB:  aluop = ALU_STB;
            OP1_STH:  aluop = ALU_STH;
            OP1_STW:  aluop = ALU_STW;
            default: ;
        endcase
    end

    assign hit_o    = (aluop != ALU_NOP);
    assign is_store = aluop inside {ALU_STB, ALU_STH, ALU_STW};

    always_comb begin
        dec_o = DECODE_NOP;
        if (hit_o) begin
            dec_o.aluop          = aluop;
            dec_o.alusel         = sel_of(aluop);
            dec_o.reg1_read_en   = 1'b1;
            dec_o.reg1_read_addr = rj_of(inst_i);
            // Store data comes from the register named in rd.
            dec_o.reg2_read_en   = is_store;
            dec_o.reg2_read_addr = is_store ? rd_of(inst_i) : rk_of(inst_i);
            dec_o.reg_write_en   = !is_store;
            dec_o.reg_write_addr = is_store ? '0 : rd_of(inst_i);
            dec_o.imm            = is_store ? '0 : si12_sext(inst_i);
        end
    end

endmodule

`default_nettype wire

// ==== decoder/alu_decoder.sv ====
`default_nettype none

module alu_decoder
    import la_decode_pkg::*;
(
    input  wire logic [XLEN-1:0] inst_i,
    output logic                 hit_o,
    output decode_t              dec_o
);

    logic [9:0]      opcode1;
    logic [16:0]     opcode2;
    logic [6:0]      opcode3;
    aluop_e          aluop;
    logic            reg_form;
    logic [XLEN-1:0] imm;

    assign opcode1 = inst_i[31:22];
    assign opcode2 = inst_i[31:15];
    assign opcode3 = inst_i[31:25];

    // The prefix groups never overlap, so at most one case matches.
    always_comb begin
        aluop = ALU_NOP;
        case (opcode1)
            OP1_SLTI:  aluop = ALU_SLTI;
            OP1_SLTUI: aluop = ALU_SLTUI;
            OP1_ADDIW: aluop = ALU_ADDIW;
            OP1_ANDI:  aluop = ALU_ANDI;
            OP1_ORI:   aluop = ALU_ORI;
            OP1_XORI:  aluop = ALU_XORI;
            default: ;
        endcase
        case (opcode2)
            OP2_ADDW:   aluop = ALU_ADDW;
            OP2_SUBW:   aluop = ALU_SUBW;
            OP2_SLT:    aluop = ALU_SLT;
            OP2_SLTU:   aluop = ALU_SLTU;
            OP2_NOR:    aluop = ALU_NOR;
            OP2_AND:    aluop = ALU_AND;
            OP2_OR:     aluop = ALU_OR;
            OP2_XOR:    aluop = ALU_XOR;
            OP2_SLLW:   aluop = ALU_SLLW;
            OP2_SRLW:   aluop = ALU_SRLW;
            OP2_SRAW:   aluop = ALU_SRAW;
            OP2_MULW:   aluop = ALU_MULW;
            OP2_MULHW:  aluop = ALU_MULHW;
            OP2_MULHWU: aluop = ALU_MULHWU;
            OP2_DIVW:   aluop = ALU_DIVW;
            OP2_MODW:   aluop = ALU_MODW;
            OP2_DIVWU:  aluop = ALU_DIVWU;
            OP2_MODWU:  aluop = ALU_MODWU;
            OP2_SLLIW:  aluop = ALU_SLLIW;
            OP2_SRLIW:  aluop = ALU_SRLIW;
            OP2_SRAIW:  aluop = ALU_SRAIW;
            default: ;
        endcase
        case (opcode3)
            OP3_LU12I:     aluop = ALU_LU12I;
            OP3_PCADDU12I: aluop = ALU_PCADDU12I;
            default: ;
        endcase
    end

    // Immediate forms pick their extension, the rest read rk.
    always_comb begin
        reg_form = 1'b0;
        case (aluop)
            ALU_SLTI, ALU_SLTUI, ALU_ADDIW:  imm = si12_sext(inst_i);
            ALU_ANDI, ALU_ORI, ALU_XORI:     imm = ui12_zext(inst_i);
            ALU_SLLIW, ALU_SRLIW, ALU_SRAIW: imm = ui5_zext(inst_i);
            ALU_LU12I, ALU_PCADDU12I:        imm = si20_upper(inst_i);
            default: begin
                imm      = '0;
                reg_form = 1'b1;
            end
        endcase
    end

    assign hit_o = (aluop != ALU_NOP);

    always_comb begin
        dec_o = DECODE_NOP;
        if (hit_o) begin
            dec_o.aluop          = aluop;
            dec_o.alusel         = sel_of(aluop);
            dec_o.reg1_read_en   = 1'b1;
            // LU12I adds its immediate to r0.
            dec_o.reg1_read_addr = (aluop == ALU_LU12I) ? '0 : rj_of(inst_i);
            dec_o.reg2_read_en   = reg_form;
            dec_o.reg2_read_addr = rk_of(inst_i);
            dec_o.reg_write_en   = 1'b1;
            dec_o.reg_write_addr = rd_of(inst_i);
            dec_o.imm            = imm;
        end
    end

endmodule

`default_nettype wire

// ==== common/la_decode_pkg.sv ====
`default_nettype none

package la_decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Lowest bit of each instruction field.
    localparam int RD_LSB   = 0;
    localparam int RJ_LSB   = 5;
    localparam int RK_LSB   = 10;
    localparam int SI12_LSB = 10;
    localparam int UI12_LSB = 10;
    localparam int SI14_LSB = 10;
    localparam int UI5_LSB  = 10;
    localparam int SI20_LSB = 5;

    // BL writes the return address here.
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd1;

    // Ten bit prefixes, inst[31:22].
    localparam logic [9:0] OP1_SLTI  = 10'h008;
    localparam logic [9:0] OP1_SLTUI = 10'h009;
    localparam logic [9:0] OP1_ADDIW = 10'h00a;
    localparam logic [9:0] OP1_ANDI  = 10'h00d;
    localparam logic [9:0] OP1_ORI   = 10'h00e;
    localparam logic [9:0] OP1_XORI  = 10'h00f;
    localparam logic [9:0] OP1_LDB   = 10'h0a0;
    localparam logic [9:0] OP1_LDH   = 10'h0a1;
    localparam logic [9:0] OP1_LDW   = 10'h0a2;
    localparam logic [9:0] OP1_STB   = 10'h0a4;
    localparam logic [9:0] OP1_STH   = 10'h0a5;
    localparam logic [9:0] OP1_STW   = 10'h0a6;
    localparam logic [9:0] OP1_LDBU  = 10'h0a8;
    localparam logic [9:0] OP1_LDHU  = 10'h0a9;

    // Seventeen bit prefixes, inst[31:15].
    localparam logic [16:0] OP2_ADDW    = 17'h00020;
    localparam logic [16:0] OP2_SUBW    = 17'h00022;
    localparam logic [16:0] OP2_SLT     = 17'h00024;
    localparam logic [16:0] OP2_SLTU    = 17'h00025;
    localparam logic [16:0] OP2_NOR     = 17'h00028;
    localparam logic [16:0] OP2_AND     = 17'h00029;
    localparam logic [16:0] OP2_OR      = 17'h0002a;
    localparam logic [16:0] OP2_XOR     = 17'h0002b;
    localparam logic [16:0] OP2_SLLW    = 17'h0002e;
    localparam logic [16:0] OP2_SRLW    = 17'h0002f;
    localparam logic [16:0] OP2_SRAW    = 17'h00030;
    localparam logic [16:0] OP2_MULW    = 17'h00038;
    localparam logic [16:0] OP2_MULHW   = 17'h00039;
    localparam logic [16:0] OP2_MULHWU  = 17'h0003a;
    localparam logic [16:0] OP2_DIVW    = 17'h00040;
    localparam logic [16:0] OP2_MODW    = 17'h00041;
    localparam logic [16:0] OP2_DIVWU   = 17'h00042;
    localparam logic [16:0] OP2_MODWU   = 17'h00043;
    localparam logic [16:0] OP2_BREAK   = 17'h00054;
    localparam logic [16:0] OP2_SYSCALL = 17'h00056;
    localparam logic [16:0] OP2_SLLIW   = 17'h00081;
    localparam logic [16:0] OP2_SRLIW   = 17'h00089;
    localparam logic [16:0] OP2_SRAIW   = 17'h00091;

    // Seven bit prefixes, inst[31:25].
    localparam logic [6:0] OP3_LU12I     = 7'h0a;
    localparam logic [6:0] OP3_PCADDU12I = 7'h0e;

    // Six bit prefixes, inst[31:26].
    localparam logic [5:0] OP5_JIRL = 6'h13;
    localparam logic [5:0] OP5_B    = 6'h14;
    localparam logic [5:0] OP5_BL   = 6'h15;
    localparam logic [5:0] OP5_BEQ  = 6'h16;
    localparam logic [5:0] OP5_BNE  = 6'h17;
    localparam logic [5:0] OP5_BLT  = 6'h18;
    localparam logic [5:0] OP5_BGE  = 6'h19;
    localparam logic [5:0] OP5_BLTU = 6'h1a;
    localparam logic [5:0] OP5_BGEU = 6'h1b;

    typedef enum logic [2:0] {
        ALU_SEL_NOP         = 3'd0,
        ALU_SEL_LOGIC       = 3'd1,
        ALU_SEL_SHIFT       = 3'd2,
        ALU_SEL_ARITHMETIC  = 3'd3,
        ALU_SEL_LOAD_STORE  = 3'd4,
        ALU_SEL_JUMP_BRANCH = 3'd5
    } alusel_e;

    // The top three bits of an ALU op carry its select.
    // SLTI and SLTUI sit in the shift group.
    typedef enum logic [7:0] {
        ALU_NOP       = 8'h00,
        ALU_NOR       = 8'h20,
        ALU_AND       = 8'h21,
        ALU_OR        = 8'h22,
        ALU_XOR       = 8'h23,
        ALU_ANDI      = 8'h24,
        ALU_ORI       = 8'h25,
        ALU_XORI      = 8'h26,
        ALU_LU12I     = 8'h27,
        ALU_SLLW      = 8'h40,
        ALU_SRLW      = 8'h41,
        ALU_SRAW      = 8'h42,
        ALU_SLLIW     = 8'h43,
        ALU_SRLIW     = 8'h44,
        ALU_SRAIW     = 8'h45,
        ALU_SLTI      = 8'h46,
        ALU_SLTUI     = 8'h47,
        ALU_ADDW      = 8'h60,
        ALU_SUBW      = 8'h61,
        ALU_SLT       = 8'h62,
        ALU_SLTU      = 8'h63,
        ALU_MULW      = 8'h64,
        ALU_MULHW     = 8'h65,
        ALU_MULHWU    = 8'h66,
        ALU_DIVW      = 8'h67,
        ALU_MODW      = 8'h68,
        ALU_DIVWU     = 8'h69,
        ALU_MODWU     = 8'h6a,
        ALU_ADDIW     = 8'h6b,
        ALU_PCADDU12I = 8'h6c,
        ALU_LDB       = 8'h80,
        ALU_LDH       = 8'h81,
        ALU_LDW       = 8'h82,
        ALU_LDBU      = 8'h83,
        ALU_LDHU      = 8'h84,
        ALU_STB       = 8'h85,
        ALU_STH       = 8'h86,
        ALU_STW       = 8'h87,
        ALU_BEQ       = 8'ha0,
        ALU_BNE       = 8'ha1,
        ALU_BLT       = 8'ha2,
        ALU_BGE       = 8'ha3,
        ALU_B         = 8'ha4,
        ALU_BL        = 8'ha5,
        ALU_JIRL      = 8'ha6
    } aluop_e;

    typedef enum logic [6:0] {
        EXC_SYS = 7'h0b,
        EXC_BRK = 7'h0c,
        EXC_INE = 7'h0d
    } exc_cause_e;

    typedef struct packed {
        aluop_e                aluop;
        alusel_e               alusel;
        logic                  reg1_read_en;
        logic [REG_ADDR_W-1:0] reg1_read_addr;
        logic                  reg2_read_en;
        logic [REG_ADDR_W-1:0] reg2_read_addr;
        logic                  reg_write_en;
        logic [REG_ADDR_W-1:0] reg_write_addr;
        logic [XLEN-1:0]       imm;
    } decode_t;

    // Decoders put rj and rk on the read addresses once they hit.
    localparam decode_t DECODE_NOP = '{
        aluop:   ALU_NOP,
        alusel:  ALU_SEL_NOP,
        default: '0
    };

    function automatic alusel_e sel_of(input aluop_e op);
        return alusel_e'(op[7:5]);
    endfunction

    function automatic logic [REG_ADDR_W-1:0] rd_of(input logic [XLEN-1:0] inst);
        return inst[RD_LSB +: REG_ADDR_W];
    endfunction

    function automatic logic [REG_ADDR_W-1:0] rj_of(input logic [XLEN-1:0] inst);
        return inst[RJ_LSB +: REG_ADDR_W];
    endfunction

    function automatic logic [REG_ADDR_W-1:0] rk_of(input logic [XLEN-1:0] inst);
        return inst[RK_LSB +: REG_ADDR_W];
    endfunction

    function automatic logic [XLEN-1:0] si12_sext(input logic [XLEN-1:0] inst);
        return {{20{inst[SI12_LSB+11]}}, inst[SI12_LSB +: 12]};
    endfunction

    function automatic logic [XLEN-1:0] ui12_zext(input logic [XLEN-1:0] inst);
        return {20'b0, inst[UI12_LSB +: 12]};
    endfunction

    function automatic logic [XLEN-1:0] ui5_zext(input logic [XLEN-1:0] inst);
        return {27'b0, inst[UI5_LSB +: 5]};
    endfunction

    function automatic logic [XLEN-1:0] si20_upper(input logic [XLEN-1:0] inst);
        return {inst[SI20_LSB +: 20], 12'b0};
    endfunction

endpackage

`default_nettype wire
